// File: dv/lj_eval_tb.sv
// Testbench with clock, reset, stimulus table, reference queue, output checks and timeout
`timescale 1ns/1ns

module lj_eval_tb;

	import lj_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Configuration
	////////////////////////////////////////////////////////////////////////////

	localparam int IN_DEPTH = 4;
	localparam int FILTER_DEPTH = 32;
	localparam int OUT_DEPTH = 64;
	localparam logic [R2_WIDTH-1:0] CUTOFF_2 = 144;
	localparam int TABLE_LEN = 24;
	// Pairs the design may hold while downstream stalls
	localparam int CAPACITY = IN_DEPTH + FILTER_DEPTH + OUT_DEPTH;
	localparam int CYCLE_LIMIT = (TABLE_LEN + CAPACITY + 1) * 40 + 200;

	logic clk;
	logic rst;
	logic ivalid;
	logic iready;
	pair_in_t in_pair;
	logic oready;
	logic ovalid;
	force_out_t out_force;

	// Stimulus table with hand-worked keep flags
	pair_in_t table_pair [TABLE_LEN];
	logic table_keep [TABLE_LEN];

	// Expected results in output order
	force_out_t expected_q [$];
	force_out_t want_force;

	int value_errors;
	int other_errors;
	int cycle_count;
	logic hold_low;
	logic last_iready;
	logic [31:0] ready_state;
	logic [31:0] coord_state;

	lj_eval_top
	#(
		.IN_DEPTH(IN_DEPTH),
		.FILTER_DEPTH(FILTER_DEPTH),
		.OUT_DEPTH(OUT_DEPTH),
		.CUTOFF_2(CUTOFF_2)
	)
	dut0
	(
		.clk(clk),
		.rst(rst),
		.ivalid(ivalid),
		.in_pair(in_pair),
		.oready(oready),
		.iready(iready),
		.ovalid(ovalid),
		.out_force(out_force)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Each component is the axis difference times the cutoff margin
	function automatic force_out_t expected_force(input pair_in_t p);
		force_out_t f;
		longint dx;
		longint dy;
		longint dz;
		longint margin;
		dx = longint'(p.nbrx) - longint'(p.refx);
		dy = longint'(p.nbry) - longint'(p.refy);
		dz = longint'(p.nbrz) - longint'(p.refz);
		margin = longint'(CUTOFF_2) - (dx * dx + dy * dy + dz * dz);
		f.ref_id = p.ref_id;
		f.nbr_id = p.nbr_id;
		f.fx = FORCE_WIDTH'(dx * margin);
		f.fy = FORCE_WIDTH'(dy * margin);
		f.fz = FORCE_WIDTH'(dz * margin);
		return f;
	endfunction

	// Random pair with every axis offset within 3 so it stays inside the cutoff
	function automatic pair_in_t near_pair(input int idx, input logic [31:0] r);
		pair_in_t p;
		p.ref_id = ID_WIDTH'(32'h100000 + idx);
		p.nbr_id = ID_WIDTH'(idx * 3);
		p.refx = {{8{r[7]}}, r[7:0]};
		p.refy = {{8{r[15]}}, r[15:8]};
		p.refz = {{8{r[23]}}, r[23:16]};
		p.nbrx = COORD_WIDTH'(int'(p.refx) + int'(r[26:24]) % 7 - 3);
		p.nbry = COORD_WIDTH'(int'(p.refy) + int'(r[29:27]) % 7 - 3);
		p.nbrz = COORD_WIDTH'(int'(p.refz) + int'(r[31:30]) - 2);
		return p;
	endfunction

	task automatic set_entry(input int idx, input int rx, input int ry, input int rz,
		input int nx, input int ny, input int nz, input logic keep);
		pair_in_t p;
		p.ref_id = ID_WIDTH'(32'h0A000 + idx * 37);
		p.nbr_id = ID_WIDTH'(32'h1F0000 + idx * 1031);
		p.refx = COORD_WIDTH'(rx);
		p.refy = COORD_WIDTH'(ry);
		p.refz = COORD_WIDTH'(rz);
		p.nbrx = COORD_WIDTH'(nx);
		p.nbry = COORD_WIDTH'(ny);
		p.nbrz = COORD_WIDTH'(nz);
		table_pair[idx] = p;
		table_keep[idx] = keep;
	endtask

	// Positions and keep flag for r2 < 144 with r2 noted per line
	task automatic fill_table();
		set_entry(0, 0, 0, 0, 1, 2, 3, 1'b1);                   // 14
		set_entry(1, 10, 10, 10, 7, 8, 9, 1'b1);                // 14 with all differences negative
		set_entry(2, 0, 0, 0, 9, 6, 5, 1'b1);                   // 142 since 143 is no sum of 3 squares
		set_entry(3, 0, 0, 0, 12, 0, 0, 1'b0);                  // 144
		set_entry(4, 0, 0, 0, 12, 1, 0, 1'b0);                  // 145
		set_entry(5, -5, -5, -5, -5, -5, -5, 1'b1);             // 0
		set_entry(6, 100, -200, 50, 92, -196, 51, 1'b1);        // 81
		set_entry(7, -1000, 2000, -3000, -1000, 2000, -2989, 1'b1); // 121
		set_entry(8, 0, 0, 0, -8, -8, -4, 1'b0);                // 144
		set_entry(9, 3, 3, 3, -6, -5, -2, 1'b0);                // 170
		set_entry(10, 20, 20, 20, 29, 28, 20, 1'b0);            // 145
		set_entry(11, -32768, -32768, -32768, -32760, -32763, -32766, 1'b1); // 93
		set_entry(12, 32767, 32767, 32767, 32760, 32765, 32767, 1'b1);       // 53
		set_entry(13, 0, 0, 0, -11, -4, -3, 1'b0);              // 146
		set_entry(14, 0, 0, 0, -11, -3, -3, 1'b1);              // 139
		set_entry(15, 50, 50, 50, 50, 50, 38, 1'b0);            // 144
		set_entry(16, 50, 50, 50, 50, 51, 39, 1'b1);            // 122
		set_entry(17, 7, -7, 7, -3, -7, 7, 1'b1);               // 100
		set_entry(18, -32768, 0, 0, 32767, 0, 0, 1'b0);         // full-range span
		set_entry(19, 1, 1, 1, 2, 2, 2, 1'b1);                  // 3
		set_entry(20, -100, -100, -100, -106, -107, -105, 1'b1); // 110
		set_entry(21, 0, 0, 0, -9, -6, -5, 1'b1);               // 142
		set_entry(22, 0, 0, 0, 0, -12, -1, 1'b0);               // 145
		set_entry(23, 40, -40, 40, 44, -44, 44, 1'b1);          // 48
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	// Called just after a rising edge and returns on the edge that took the pair
	task automatic send_pair(input pair_in_t p, input logic keep);
		logic taken;
		ivalid <= 1'b1;
		in_pair <= p;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = oready;
			@(posedge clk);
		end
		if (keep)
		begin
			expected_q.push_back(expected_force(p));
		end
	endtask

	// Block until every expected result has come out
	task automatic wait_drain();
		while (expected_q.size() != 0)
		begin
			@(posedge clk);
		end
	endtask

	task automatic print_counts();
		$display("Checks finished with %0d value errors and %0d other errors",
			value_errors, other_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Downstream pull, output monitor and cycle limit
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst || hold_low)
		begin
			iready <= 1'b0;
		end
		else
		begin
			// High about three cycles in four
			ready_state = xorshift(ready_state);
			iready <= (ready_state[1:0] != 2'b00);
		end
	end

	// Outputs checked on the falling edge
	always @(negedge clk)
	begin
		if (!rst && ovalid)
		begin
			if (!last_iready)
			begin
				$display("ovalid was high although iready was low on the cycle before");
				other_errors++;
			end
			if (expected_q.size() == 0)
			begin
				$display("ovalid was high while no kept pair was outstanding");
				other_errors++;
			end
			else
			begin
				want_force = expected_q.pop_front();
				check_value("out_force.ref_id", 64'(out_force.ref_id), 64'(want_force.ref_id));
				check_value("out_force.nbr_id", 64'(out_force.nbr_id), 64'(want_force.nbr_id));
				check_value("out_force.fx", 64'(out_force.fx), 64'(want_force.fx));
				check_value("out_force.fy", 64'(out_force.fy), 64'(want_force.fy));
				check_value("out_force.fz", 64'(out_force.fz), 64'(want_force.fz));
			end
		end
		// Level seen by the DUT at the next edge
		last_iready = iready;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d pairs still outstanding",
				cycle_count, expected_q.size());
			other_errors++;
			print_counts();
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int accepted;
		logic saw_low;
		pair_in_t burst;
		rst = 1'b1;
		ivalid = 1'b0;
		iready = 1'b0;
		in_pair = '0;
		hold_low = 1'b0;
		last_iready = 1'b0;
		value_errors = 0;
		other_errors = 0;
		cycle_count = 0;
		ready_state = 32'd31795;
		coord_state = 32'd31795;
		fill_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Idle levels before any input
		@(negedge clk);
		check_value("ovalid", 64'(ovalid), 64'd0);
		check_value("oready", 64'(oready), 64'd1);
		@(posedge clk);

		// Table pairs with random downstream stalls
		for (int i = 0; i < TABLE_LEN; i++)
		begin
			send_pair(table_pair[i], table_keep[i]);
		end
		ivalid <= 1'b0;
		wait_drain();

		// Burst with downstream stalled until oready falls
		@(negedge clk);
		hold_low = 1'b1;
		repeat (2) @(posedge clk);
		accepted = 0;
		saw_low = 1'b0;
		while (!saw_low && accepted <= CAPACITY)
		begin
			coord_state = xorshift(coord_state);
			burst = near_pair(accepted, coord_state);
			ivalid <= 1'b1;
			in_pair <= burst;
			@(negedge clk);
			saw_low = !oready;
			@(posedge clk);
			if (!saw_low)
			begin
				expected_q.push_back(expected_force(burst));
				accepted++;
			end
		end
		ivalid <= 1'b0;
		if (!saw_low)
		begin
			$display("oready stayed high after %0d pairs with iready held low", accepted);
			other_errors++;
		end

		// Release downstream so everything accepted drains
		@(negedge clk);
		hold_low = 1'b0;
		wait_drain();
		// Quiet tail so a stray ovalid reaches the monitor
		repeat (20) @(posedge clk);

		print_counts();
		if (value_errors == 0 && other_errors == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: logic/lj_eval_top.sv
// Top level with input and output buffers, filter, force pipeline and flow-control levels
`timescale 1ns/1ns

module lj_eval_top
#(
	parameter int IN_DEPTH = 4,
	parameter int FILTER_DEPTH = 32,
	parameter int OUT_DEPTH = 64,
	parameter logic [lj_pkg::R2_WIDTH-1:0] CUTOFF_2 = 144
)
(
	input logic clk,
	input logic rst,
	// Upstream side
	input logic ivalid,
	input lj_pkg::pair_in_t in_pair,
	output logic oready,
	// Downstream side
	input logic iready,
	output logic ovalid,
	output lj_pkg::force_out_t out_force
);

	import lj_pkg::*;

	localparam int IN_CW = $clog2(IN_DEPTH+1);
	localparam int OUT_CW = $clog2(OUT_DEPTH+1);

	////////////////////////////////////////////////////////////////////////////
	// Control signals
	////////////////////////////////////////////////////////////////////////////

	// Input buffer
	logic in_wr;
	logic in_rd;
	logic in_empty;
	logic [IN_CW-1:0] in_used;
	pair_in_t in_q;
	logic filt_valid;

	// Filter and its buffer
	logic filter_full;
	logic avail;
	logic take;
	logic take_valid;
	pair_r2_t filt_pair;

	// Force pipeline into output buffer
	logic pipe_valid;
	force_out_t pipe_force;
	logic out_rd;
	logic out_empty;
	logic [OUT_CW-1:0] out_used;

	// Level stays high while more than two input slots are free
	assign oready = (int'(in_used) < (IN_DEPTH - 2));
	assign in_wr = ivalid && oready;

	// Feed the filter unless its buffer is close to full
	assign in_rd = ~in_empty && ~filter_full;

	// Room for the pair read now, the one at the pipe input and FORCE_LATENCY in flight
	assign take = avail && ((OUT_DEPTH - int'(out_used)) >= (FORCE_LATENCY + 2));

	// Downstream pull
	assign out_rd = iready && ~out_empty;

	// Each buffer read shows data one cycle later
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			filt_valid <= 1'b0;
			take_valid <= 1'b0;
			ovalid <= 1'b0;
		end
		else
		begin
			filt_valid <= in_rd;
			take_valid <= take;
			// Single-cycle strobe that downstream must take
			ovalid <= out_rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Input buffer
	////////////////////////////////////////////////////////////////////////////

	pair_fifo
	#(
		.payload_t(pair_in_t),
		.DEPTH(IN_DEPTH)
	)
	in_buf
	(
		.clk(clk),
		.rst(rst),
		.wr(in_wr),
		.din(in_pair),
		.rd(in_rd),
		.q(in_q),
		.empty(in_empty),
		.used(in_used)
	);

	////////////////////////////////////////////////////////////////////////////
	// Filter and force pipeline
	////////////////////////////////////////////////////////////////////////////

	pair_filter
	#(
		.DEPTH(FILTER_DEPTH),
		.CUTOFF_2(CUTOFF_2)
	)
	filter0
	(
		.clk(clk),
		.rst(rst),
		.in_valid(filt_valid),
		.in_pair(in_q),
		.take(take),
		.avail(avail),
		.filter_full(filter_full),
		.out_pair(filt_pair)
	);

	lj_force_pipeline
	#(
		.CUTOFF_2(CUTOFF_2)
	)
	force0
	(
		.clk(clk),
		.rst(rst),
		.in_valid(take_valid),
		.in_pair(filt_pair),
		.out_valid(pipe_valid),
		.out_force(pipe_force)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output buffer
	////////////////////////////////////////////////////////////////////////////

	pair_fifo
	#(
		.payload_t(force_out_t),
		.DEPTH(OUT_DEPTH)
	)
	out_buf
	(
		.clk(clk),
		.rst(rst),
		.wr(pipe_valid),
		.din(pipe_force),
		.rd(out_rd),
		.q(out_force),
		.empty(out_empty),
		.used(out_used)
	);

endmodule

// File: logic/lj_force_pipeline.sv
// Two-stage force pipeline from differences and r2 to force components, IDs carried along
`timescale 1ns/1ns

module lj_force_pipeline
#(
	parameter logic [lj_pkg::R2_WIDTH-1:0] CUTOFF_2 = 144
)
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input lj_pkg::pair_r2_t in_pair,
	output logic out_valid,
	output lj_pkg::force_out_t out_force
);

	import lj_pkg::*;

	// Stage one registers
	logic s1_valid;
	logic [ID_WIDTH-1:0] s1_ref_id;
	logic [ID_WIDTH-1:0] s1_nbr_id;
	logic signed [DIFF_WIDTH-1:0] s1_dx;
	logic signed [DIFF_WIDTH-1:0] s1_dy;
	logic signed [DIFF_WIDTH-1:0] s1_dz;
	// One bit wider than r2 so the sign survives
	logic signed [R2_WIDTH:0] s1_margin;

	////////////////////////////////////////////////////////////////////////////
	// Valid chain
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Margin then products
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// Cutoff margin is positive for every kept pair
		s1_margin <= $signed({1'b0, CUTOFF_2}) - $signed({1'b0, in_pair.r2});
		s1_ref_id <= in_pair.ref_id;
		s1_nbr_id <= in_pair.nbr_id;
		s1_dx <= in_pair.dx;
		s1_dy <= in_pair.dy;
		s1_dz <= in_pair.dz;

		// Signed product of exactly DIFF_WIDTH + R2_WIDTH + 1 bits
		out_force.ref_id <= s1_ref_id;
		out_force.nbr_id <= s1_nbr_id;
		out_force.fx <= s1_dx * s1_margin;
		out_force.fy <= s1_dy * s1_margin;
		out_force.fz <= s1_dz * s1_margin;
	end

endmodule

// File: logic/lj_pkg.sv
// Widths, pair and force structs, and pipeline latencies for the pair force evaluator
package lj_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////////////////////

	// Particle ID as three cell fields plus a cell address
	localparam int CELL_ID_WIDTH = 4;
	localparam int CELL_ADDR_WIDTH = 9;
	localparam int ID_WIDTH = 3 * CELL_ID_WIDTH + CELL_ADDR_WIDTH;

	// Signed fixed-point position
	localparam int COORD_WIDTH = 16;
	// One extra bit so neighbor minus reference never wraps
	localparam int DIFF_WIDTH = COORD_WIDTH + 1;
	// Unsigned sum of three squares with headroom
	localparam int R2_WIDTH = 36;
	// Difference times signed margin
	localparam int FORCE_WIDTH = DIFF_WIDTH + R2_WIDTH + 1;

	// Fixed pipeline depths in cycles
	localparam int R2_LATENCY = 3;
	localparam int FORCE_LATENCY = 2;

	////////////////////////////////////////////////////////////////////////////
	// Payload structs with the first field in the MSBs
	////////////////////////////////////////////////////////////////////////////

	// Pair as it arrives from upstream
	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nbr_id;
		logic signed [COORD_WIDTH-1:0] refx;
		logic signed [COORD_WIDTH-1:0] refy;
		logic signed [COORD_WIDTH-1:0] refz;
		logic signed [COORD_WIDTH-1:0] nbrx;
		logic signed [COORD_WIDTH-1:0] nbry;
		logic signed [COORD_WIDTH-1:0] nbrz;
	} pair_in_t;

	// Pair after the distance stage
	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nbr_id;
		logic signed [DIFF_WIDTH-1:0] dx;
		logic signed [DIFF_WIDTH-1:0] dy;
		logic signed [DIFF_WIDTH-1:0] dz;
		logic [R2_WIDTH-1:0] r2;
	} pair_r2_t;

	// Result sent downstream
	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nbr_id;
		logic signed [FORCE_WIDTH-1:0] fx;
		logic signed [FORCE_WIDTH-1:0] fy;
		logic signed [FORCE_WIDTH-1:0] fz;
	} force_out_t;

endpackage

// File: logic/pair_fifo.sv
// Synchronous FIFO with a type-parameter payload, registered read data and a used-word count
`timescale 1ns/1ns

module pair_fifo
#(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 16
)
(
	input logic clk,
	input logic rst,
	input logic wr,
	input payload_t din,
	input logic rd,
	output payload_t q,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] used
);

	// Pointer and count widths
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH+1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic wr_ok;
	logic rd_ok;

	// Wrap at DEPTH even when it is not a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH-1))
		begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Read of an empty buffer is ignored
	assign rd_ok = rd && (count != '0);
	// Full buffer still takes a write when a read frees a slot
	assign wr_ok = wr && ((count < CW'(DEPTH)) || rd_ok);

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_ok)
			begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_ok)
			begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Simultaneous read and write leave the count alone
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk)
	begin
		if (wr_ok)
		begin
			mem[wr_ptr] <= din;
		end
		// Data lands on q one cycle after rd
		if (rd_ok)
		begin
			q <= mem[rd_ptr];
		end
	end

	assign empty = (count == '0);
	assign used = count;

endmodule

// File: logic/pair_filter.sv
// Cutoff filter with r2 pipeline, filter buffer and back-pressure flag
`timescale 1ns/1ns

module pair_filter
#(
	parameter int DEPTH = 32,
	parameter logic [lj_pkg::R2_WIDTH-1:0] CUTOFF_2 = 144
)
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input lj_pkg::pair_in_t in_pair,
	input logic take,
	output logic avail,
	output logic filter_full,
	output lj_pkg::pair_r2_t out_pair
);

	import lj_pkg::*;

	localparam int CW = $clog2(DEPTH+1);

	logic r2_valid;
	pair_r2_t r2_pair;
	logic keep;
	logic buf_empty;
	logic [CW-1:0] buf_used;

	////////////////////////////////////////////////////////////////////////////
	// Squared distance
	////////////////////////////////////////////////////////////////////////////

	r2_compute r2_calc
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_pair(in_pair),
		.out_valid(r2_valid),
		.out_r2(r2_pair)
	);

	// Strictly below the cutoff so r2 equal to it is dropped
	assign keep = r2_valid && (r2_pair.r2 < CUTOFF_2);

	////////////////////////////////////////////////////////////////////////////
	// Filter buffer
	////////////////////////////////////////////////////////////////////////////

	pair_fifo
	#(
		.payload_t(pair_r2_t),
		.DEPTH(DEPTH)
	)
	filter_buf
	(
		.clk(clk),
		.rst(rst),
		.wr(keep),
		.din(r2_pair),
		.rd(take),
		.q(out_pair),
		.empty(buf_empty),
		.used(buf_used)
	);

	assign avail = ~buf_empty;

	// Stop input reads while free space is short of the pairs that may still land
	// One read this cycle, one at the filter input, R2_LATENCY in the pipe
	assign filter_full = (DEPTH - int'(buf_used)) < (R2_LATENCY + 2);

endmodule

// File: logic/r2_compute.sv
// Three-stage pipeline from two positions to per-axis differences and squared distance
`timescale 1ns/1ns

module r2_compute
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input lj_pkg::pair_in_t in_pair,
	output logic out_valid,
	output lj_pkg::pair_r2_t out_r2
);

	import lj_pkg::*;

	// IDs and differences before r2 is known
	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nbr_id;
		logic signed [DIFF_WIDTH-1:0] dx;
		logic signed [DIFF_WIDTH-1:0] dy;
		logic signed [DIFF_WIDTH-1:0] dz;
	} diff_t;

	// Stage one holds the differences with the IDs
	logic s1_valid;
	diff_t s1_pair;

	// Stage two adds the squares per axis
	logic s2_valid;
	diff_t s2_pair;
	logic [R2_WIDTH-1:0] s2_sqx;
	logic [R2_WIDTH-1:0] s2_sqy;
	logic [R2_WIDTH-1:0] s2_sqz;

	////////////////////////////////////////////////////////////////////////////
	// Valid shift chain
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Free-running datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// Neighbor minus reference widened by one bit
		s1_pair.ref_id <= in_pair.ref_id;
		s1_pair.nbr_id <= in_pair.nbr_id;
		s1_pair.dx <= $signed(in_pair.nbrx) - $signed(in_pair.refx);
		s1_pair.dy <= $signed(in_pair.nbry) - $signed(in_pair.refy);
		s1_pair.dz <= $signed(in_pair.nbrz) - $signed(in_pair.refz);

		// Squares are never negative
		s2_pair <= s1_pair;
		s2_sqx <= $signed(s1_pair.dx) * $signed(s1_pair.dx);
		s2_sqy <= $signed(s1_pair.dy) * $signed(s1_pair.dy);
		s2_sqz <= $signed(s1_pair.dz) * $signed(s1_pair.dz);

		// Sum fits R2_WIDTH with room to spare
		out_r2.ref_id <= s2_pair.ref_id;
		out_r2.nbr_id <= s2_pair.nbr_id;
		out_r2.dx <= s2_pair.dx;
		out_r2.dy <= s2_pair.dy;
		out_r2.dz <= s2_pair.dz;
		out_r2.r2 <= s2_sqx + s2_sqy + s2_sqz;
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -sv -Wno-fatal -f verilog.f --top-module lj_eval_tb \
	-Mdir obj_dir -o lj_eval_sim
./obj_dir/lj_eval_sim > sim.log
cat sim.log
if grep -q "Done: errors found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"

// File: verilog.f
logic/lj_pkg.sv
logic/pair_fifo.sv
logic/r2_compute.sv
logic/pair_filter.sv
logic/lj_force_pipeline.sv
logic/lj_eval_top.sv
dv/lj_eval_tb.sv
